// File: axi_slice_dc_master.f
+incdir+dv
hw/axi_dc_pkg.sv
hw/dc_token_ring_fifo_dout.sv
hw/dc_token_ring_fifo_din.sv
hw/axi_single_slice.sv
hw/axi_slice_dc_master.sv
dv/tb_axi_slice_dc_master.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the run from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_slice_dc_master \
    -f axi_slice_dc_master.f -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log
grep -q '^>>> PASS$' sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: dv/axi_dc_tb_tasks.svh
/*
 * Directed tests for the dual-clock AXI bridge master half.
 * Included in the testbench module and driven through its remote models.
 */

task automatic next_cycle();
    @(posedge clk_i);
    #DRIVE_DELAY;
endtask

// Remote writer stalls while full, fills the slot, then steps the token
task automatic push_aw(input aw_beat_t beat);
    @(negedge clk_i);
    while (pos_code(aw_pos) == ~axi_slave_aw_readpointer_o) begin
        @(negedge clk_i);
    end
    next_cycle();
    aw_mem[aw_pos % BUFFER_WIDTH] = beat;
    aw_pos = (aw_pos + 1) % RING_LEN;
endtask

task automatic push_w(input w_beat_t beat);
    @(negedge clk_i);
    while (pos_code(w_pos) == ~axi_slave_w_readpointer_o) begin
        @(negedge clk_i);
    end
    next_cycle();
    w_mem[w_pos % BUFFER_WIDTH] = beat;
    w_pos = (w_pos + 1) % RING_LEN;
endtask

task automatic check_reset_state();
    tests_run++;
    @(negedge clk_i);
    if (axi_master_aw_valid_o !== 1'b0) begin
        $display("ERR axi_master_aw_valid_o got %h expected %h", axi_master_aw_valid_o, 1'b0);
        errors++;
    end
    if (axi_master_w_valid_o !== 1'b0) begin
        $display("ERR axi_master_w_valid_o got %h expected %h", axi_master_w_valid_o, 1'b0);
        errors++;
    end
    if (axi_master_b_ready_o !== 1'b1) begin
        $display("ERR axi_master_b_ready_o got %h expected %h", axi_master_b_ready_o, 1'b1);
        errors++;
    end
    if (axi_slave_aw_readpointer_o !== pos_code(0)) begin
        $display("ERR axi_slave_aw_readpointer_o got %h expected %h",
                 axi_slave_aw_readpointer_o, pos_code(0));
        errors++;
    end
    if (axi_slave_w_readpointer_o !== pos_code(0)) begin
        $display("ERR axi_slave_w_readpointer_o got %h expected %h",
                 axi_slave_w_readpointer_o, pos_code(0));
        errors++;
    end
    if (axi_slave_b_writetoken_o !== pos_code(0)) begin
        $display("ERR axi_slave_b_writetoken_o got %h expected %h",
                 axi_slave_b_writetoken_o, pos_code(0));
        errors++;
    end
endtask

task automatic test_aw_latency();
    aw_beat_t beat;
    int       edges;
    tests_run++;
    beat = '{addr: 32'h8000_1234, prot: 3'h5, region: 4'ha, len: 8'h0f, size: 3'h3,
             burst: 2'h1, lock: 1'b1, cache: 4'h3, qos: 4'h7, id: 6'h2a, user: 6'h15};
    next_cycle();
    axi_master_aw_ready_i = 1'b1;
    push_aw(beat);
    // Count edges from the token change to the slice output
    edges = 0;
    do begin
        @(posedge clk_i);
        edges++;
        @(negedge clk_i);
    end while (!axi_master_aw_valid_o && edges < 10);
    if (!axi_master_aw_valid_o) begin
        $display("AW valid never rose after the write token changed");
        errors++;
    end else if (edges != 3) begin
        $display("ERR axi_master_aw_valid_o latency got %h expected %h", edges, 3);
        errors++;
    end
    if (aw_seen !== beat) begin
        $display("ERR axi_master_aw fields got %h expected %h", aw_seen, beat);
        errors++;
    end
    if (axi_slave_aw_readpointer_o !== pos_code(1)) begin
        $display("ERR axi_slave_aw_readpointer_o got %h expected %h",
                 axi_slave_aw_readpointer_o, pos_code(1));
        errors++;
    end
    next_cycle();
    @(negedge clk_i);
    if (axi_master_aw_valid_o !== 1'b0) begin
        $display("ERR axi_master_aw_valid_o got %h expected %h", axi_master_aw_valid_o, 1'b0);
        errors++;
    end
endtask

task automatic test_w_stream();
    w_beat_t     expected [$];
    w_beat_t     beat;
    w_beat_t     want;
    logic [95:0] noise;
    int          received;
    tests_run++;
    received = 0;
    fork
        begin : writer
            for (int i = 0; i < 40; i++) begin
                noise = {$random(seed), $random(seed), $random(seed)};
                beat  = noise[$bits(w_beat_t)-1:0];
                expected.push_back(beat);
                push_w(beat);
            end
        end
        begin : reader
            while (received < 40) begin
                next_cycle();
                axi_master_w_ready_i = 1'($random(seed));
                @(negedge clk_i);
                if (axi_master_w_valid_o && axi_master_w_ready_i) begin
                    if (expected.size() == 0) begin
                        $display("W beat arrived with nothing outstanding");
                        errors++;
                    end else begin
                        want = expected.pop_front();
                        if (w_seen !== want) begin
                            $display("ERR axi_master_w fields got %h expected %h", w_seen, want);
                            errors++;
                        end
                    end
                    received++;
                end
            end
        end
    join
    next_cycle();
    axi_master_w_ready_i = 1'b0;
endtask

task automatic test_b_fill_drain();
    b_beat_t sent [BUFFER_WIDTH];
    int      accepted;
    tests_run++;
    for (int i = 0; i < BUFFER_WIDTH; i++) begin
        sent[i] = '{resp: 2'(i), id: 6'($random(seed)), user: 6'($random(seed))};
    end
    accepted             = 0;
    b_drive              = sent[0];
    axi_master_b_valid_i = 1'b1;
    // Only one buffer's worth fits while the remote pointer is frozen
    repeat (BUFFER_WIDTH + 4) begin
        @(negedge clk_i);
        if (axi_master_b_ready_o) begin
            accepted++;
        end
        next_cycle();
        b_drive = sent[accepted % BUFFER_WIDTH];
    end
    axi_master_b_valid_i = 1'b0;
    if (accepted != BUFFER_WIDTH) begin
        $display("ERR axi_master_b_ready_o accepted got %h expected %h", accepted, BUFFER_WIDTH);
        errors++;
    end
    @(negedge clk_i);
    if (axi_master_b_ready_o !== 1'b0) begin
        $display("ERR axi_master_b_ready_o got %h expected %h", axi_master_b_ready_o, 1'b0);
        errors++;
    end
    if (axi_slave_b_writetoken_o !== pos_code(BUFFER_WIDTH)) begin
        $display("ERR axi_slave_b_writetoken_o got %h expected %h",
                 axi_slave_b_writetoken_o, pos_code(BUFFER_WIDTH));
        errors++;
    end
    for (int i = 0; i < BUFFER_WIDTH; i++) begin
        @(negedge clk_i);
        if (b_seen !== sent[i]) begin
            $display("ERR axi_slave_b fields got %h expected %h", b_seen, sent[i]);
            errors++;
        end
        next_cycle();
        b_pos = (b_pos + 1) % RING_LEN;
    end
    @(negedge clk_i);
    if (axi_master_b_ready_o !== 1'b1) begin
        $display("ERR axi_master_b_ready_o got %h expected %h", axi_master_b_ready_o, 1'b1);
        errors++;
    end
endtask

task automatic test_aw_backpressure();
    aw_beat_t    beats [3];
    logic [95:0] noise;
    int          start_pos;
    int          got;
    int          waited;
    tests_run++;
    next_cycle();
    axi_master_aw_ready_i = 1'b0;
    start_pos = aw_pos;
    for (int i = 0; i < 3; i++) begin
        noise    = {$random(seed), $random(seed), $random(seed)};
        beats[i] = noise[$bits(aw_beat_t)-1:0];
        push_aw(beats[i]);
    end
    repeat (5) next_cycle();
    // Slice holds the first beat while the master stalls
    repeat (6) begin
        @(negedge clk_i);
        if (!axi_master_aw_valid_o || aw_seen !== beats[0]) begin
            $display("ERR axi_master_aw fields got %h expected %h", aw_seen, beats[0]);
            errors++;
        end
        next_cycle();
    end
    if (axi_slave_aw_readpointer_o !== pos_code((start_pos + 1) % RING_LEN)) begin
        $display("ERR axi_slave_aw_readpointer_o got %h expected %h",
                 axi_slave_aw_readpointer_o, pos_code((start_pos + 1) % RING_LEN));
        errors++;
    end
    axi_master_aw_ready_i = 1'b1;
    got    = 0;
    waited = 0;
    while (got < 3 && waited < 30) begin
        @(negedge clk_i);
        if (axi_master_aw_valid_o) begin
            if (aw_seen !== beats[got]) begin
                $display("ERR axi_master_aw fields got %h expected %h", aw_seen, beats[got]);
                errors++;
            end
            got++;
        end
        next_cycle();
        waited++;
    end
    if (got != 3) begin
        $display("only %0d of 3 AW beats arrived after the stall was released", got);
        errors++;
    end
    axi_master_aw_ready_i = 1'b0;
endtask

// File: dv/tb_axi_slice_dc_master.sv
/*
 * Testbench for the master half of the dual-clock AXI write bridge.
 * Models the remote AW/W writers and the remote B reader around the DUT.
 */
module tb_axi_slice_dc_master
    import axi_dc_pkg::*;
();

    localparam int CLK_HALF       = 20;
    localparam int DRIVE_DELAY    = 2;
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int RING_LEN       = 2 * BUFFER_WIDTH;

    logic                        clk_i;
    logic                        arst_n_i;

    logic [AXI_ADDR_WIDTH-1:0]   axi_slave_aw_addr_i;
    logic [2:0]                  axi_slave_aw_prot_i;
    logic [3:0]                  axi_slave_aw_region_i;
    logic [7:0]                  axi_slave_aw_len_i;
    logic [2:0]                  axi_slave_aw_size_i;
    logic [1:0]                  axi_slave_aw_burst_i;
    logic                        axi_slave_aw_lock_i;
    logic [3:0]                  axi_slave_aw_cache_i;
    logic [3:0]                  axi_slave_aw_qos_i;
    logic [AXI_ID_WIDTH-1:0]     axi_slave_aw_id_i;
    logic [AXI_USER_WIDTH-1:0]   axi_slave_aw_user_i;
    logic [BUFFER_WIDTH-1:0]     axi_slave_aw_writetoken_i;
    logic [BUFFER_WIDTH-1:0]     axi_slave_aw_readpointer_o;

    logic [AXI_DATA_WIDTH-1:0]   axi_slave_w_data_i;
    logic [AXI_DATA_WIDTH/8-1:0] axi_slave_w_strb_i;
    logic [AXI_USER_WIDTH-1:0]   axi_slave_w_user_i;
    logic                        axi_slave_w_last_i;
    logic [BUFFER_WIDTH-1:0]     axi_slave_w_writetoken_i;
    logic [BUFFER_WIDTH-1:0]     axi_slave_w_readpointer_o;

    logic [1:0]                  axi_slave_b_resp_o;
    logic [AXI_ID_WIDTH-1:0]     axi_slave_b_id_o;
    logic [AXI_USER_WIDTH-1:0]   axi_slave_b_user_o;
    logic [BUFFER_WIDTH-1:0]     axi_slave_b_writetoken_o;
    logic [BUFFER_WIDTH-1:0]     axi_slave_b_readpointer_i;

    logic                        axi_master_aw_valid_o;
    logic [AXI_ADDR_WIDTH-1:0]   axi_master_aw_addr_o;
    logic [2:0]                  axi_master_aw_prot_o;
    logic [3:0]                  axi_master_aw_region_o;
    logic [7:0]                  axi_master_aw_len_o;
    logic [2:0]                  axi_master_aw_size_o;
    logic [1:0]                  axi_master_aw_burst_o;
    logic                        axi_master_aw_lock_o;
    logic [3:0]                  axi_master_aw_cache_o;
    logic [3:0]                  axi_master_aw_qos_o;
    logic [AXI_ID_WIDTH-1:0]     axi_master_aw_id_o;
    logic [AXI_USER_WIDTH-1:0]   axi_master_aw_user_o;
    logic                        axi_master_aw_ready_i;

    logic                        axi_master_w_valid_o;
    logic [AXI_DATA_WIDTH-1:0]   axi_master_w_data_o;
    logic [AXI_DATA_WIDTH/8-1:0] axi_master_w_strb_o;
    logic [AXI_USER_WIDTH-1:0]   axi_master_w_user_o;
    logic                        axi_master_w_last_o;
    logic                        axi_master_w_ready_i;

    logic                        axi_master_b_valid_i;
    logic [1:0]                  axi_master_b_resp_i;
    logic [AXI_ID_WIDTH-1:0]     axi_master_b_id_i;
    logic [AXI_USER_WIDTH-1:0]   axi_master_b_user_i;
    logic                        axi_master_b_ready_o;

    // Remote side state
    aw_beat_t aw_mem [BUFFER_WIDTH];
    w_beat_t  w_mem  [BUFFER_WIDTH];
    int       aw_pos;
    int       w_pos;
    int       b_pos;
    b_beat_t  b_drive;

    aw_beat_t aw_seen;
    w_beat_t  w_seen;
    b_beat_t  b_seen;

    int       errors;
    int       tests_run;
    int       cycles;
    integer   seed;

    // Johnson code of a ring position as ones fill from bit 0 and then drain
    function automatic logic [BUFFER_WIDTH-1:0] pos_code(input int pos);
        logic [BUFFER_WIDTH-1:0] code;
        code = '0;
        for (int i = 0; i < BUFFER_WIDTH; i++) begin
            if (pos > i && pos <= i + BUFFER_WIDTH) begin
                code[i] = 1'b1;
            end
        end
        return code;
    endfunction

    function automatic int code_slot(input logic [BUFFER_WIDTH-1:0] code);
        int slot;
        slot = 0;
        for (int p = 0; p < RING_LEN; p++) begin
            if (pos_code(p) == code) begin
                slot = p % BUFFER_WIDTH;
            end
        end
        return slot;
    endfunction

    // Remote buffers show the entry our read pointer selects
    assign axi_slave_aw_writetoken_i = pos_code(aw_pos);
    assign {axi_slave_aw_addr_i, axi_slave_aw_prot_i, axi_slave_aw_region_i,
            axi_slave_aw_len_i, axi_slave_aw_size_i, axi_slave_aw_burst_i,
            axi_slave_aw_lock_i, axi_slave_aw_cache_i, axi_slave_aw_qos_i,
            axi_slave_aw_id_i, axi_slave_aw_user_i}
        = aw_mem[code_slot(axi_slave_aw_readpointer_o)];

    assign axi_slave_w_writetoken_i = pos_code(w_pos);
    assign {axi_slave_w_data_i, axi_slave_w_strb_i, axi_slave_w_user_i, axi_slave_w_last_i}
        = w_mem[code_slot(axi_slave_w_readpointer_o)];

    assign axi_slave_b_readpointer_i = pos_code(b_pos);
    assign {axi_master_b_resp_i, axi_master_b_id_i, axi_master_b_user_i} = b_drive;

    assign aw_seen = {axi_master_aw_addr_o, axi_master_aw_prot_o, axi_master_aw_region_o,
                      axi_master_aw_len_o, axi_master_aw_size_o, axi_master_aw_burst_o,
                      axi_master_aw_lock_o, axi_master_aw_cache_o, axi_master_aw_qos_o,
                      axi_master_aw_id_o, axi_master_aw_user_o};
    assign w_seen  = {axi_master_w_data_o, axi_master_w_strb_o, axi_master_w_user_o,
                      axi_master_w_last_o};
    assign b_seen  = {axi_slave_b_resp_o, axi_slave_b_id_o, axi_slave_b_user_o};

    axi_slice_dc_master #(
        .AXI_ADDR_WIDTH ( AXI_ADDR_WIDTH ),
        .AXI_DATA_WIDTH ( AXI_DATA_WIDTH ),
        .AXI_ID_WIDTH   ( AXI_ID_WIDTH   ),
        .AXI_USER_WIDTH ( AXI_USER_WIDTH ),
        .BUFFER_WIDTH   ( BUFFER_WIDTH   )
    ) UUT (.*);

    always #CLK_HALF clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    `include "axi_dc_tb_tasks.svh"

    initial begin
        clk_i                 = 1'b0;
        arst_n_i              = 1'b0;
        axi_master_aw_ready_i = 1'b0;
        axi_master_w_ready_i  = 1'b0;
        axi_master_b_valid_i  = 1'b0;
        b_drive               = '0;
        aw_pos                = 0;
        w_pos                 = 0;
        b_pos                 = 0;
        errors                = 0;
        tests_run             = 0;
        cycles                = 0;
        seed                  = 32'h459a_99bc;
        for (int i = 0; i < BUFFER_WIDTH; i++) begin
            aw_mem[i] = '0;
            w_mem[i]  = '0;
        end

        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY;
        arst_n_i = 1'b1;

        check_reset_state();
        test_aw_latency();
        test_w_stream();
        test_b_fill_drain();
        test_aw_backpressure();

        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: hw/axi_slice_dc_master.sv
/*
 * Master half of a dual-clock AXI4 write bridge.
 * AW and W arrive through remote-buffered token-ring FIFOs and a register
 * slice; B leaves through a local token-ring FIFO.
 */
module axi_slice_dc_master
    import axi_dc_pkg::*;
#(
    parameter int AXI_ADDR_WIDTH = axi_dc_pkg::AXI_ADDR_WIDTH,
    parameter int AXI_DATA_WIDTH = axi_dc_pkg::AXI_DATA_WIDTH,
    parameter int AXI_ID_WIDTH   = axi_dc_pkg::AXI_ID_WIDTH,
    parameter int AXI_USER_WIDTH = axi_dc_pkg::AXI_USER_WIDTH,
    parameter int BUFFER_WIDTH   = axi_dc_pkg::BUFFER_WIDTH
) (
    input  logic                        clk_i,
    input  logic                        arst_n_i,

    // Remote AW
    input  logic [AXI_ADDR_WIDTH-1:0]   axi_slave_aw_addr_i,
    input  logic [2:0]                  axi_slave_aw_prot_i,
    input  logic [3:0]                  axi_slave_aw_region_i,
    input  logic [7:0]                  axi_slave_aw_len_i,
    input  logic [2:0]                  axi_slave_aw_size_i,
    input  logic [1:0]                  axi_slave_aw_burst_i,
    input  logic                        axi_slave_aw_lock_i,
    input  logic [3:0]                  axi_slave_aw_cache_i,
    input  logic [3:0]                  axi_slave_aw_qos_i,
    input  logic [AXI_ID_WIDTH-1:0]     axi_slave_aw_id_i,
    input  logic [AXI_USER_WIDTH-1:0]   axi_slave_aw_user_i,
    input  logic [BUFFER_WIDTH-1:0]     axi_slave_aw_writetoken_i,
    output logic [BUFFER_WIDTH-1:0]     axi_slave_aw_readpointer_o,

    // Remote W
    input  logic [AXI_DATA_WIDTH-1:0]   axi_slave_w_data_i,
    input  logic [AXI_DATA_WIDTH/8-1:0] axi_slave_w_strb_i,
    input  logic [AXI_USER_WIDTH-1:0]   axi_slave_w_user_i,
    input  logic                        axi_slave_w_last_i,
    input  logic [BUFFER_WIDTH-1:0]     axi_slave_w_writetoken_i,
    output logic [BUFFER_WIDTH-1:0]     axi_slave_w_readpointer_o,

    // Remote B
    output logic [1:0]                  axi_slave_b_resp_o,
    output logic [AXI_ID_WIDTH-1:0]     axi_slave_b_id_o,
    output logic [AXI_USER_WIDTH-1:0]   axi_slave_b_user_o,
    output logic [BUFFER_WIDTH-1:0]     axi_slave_b_writetoken_o,
    input  logic [BUFFER_WIDTH-1:0]     axi_slave_b_readpointer_i,

    // Local AW master
    output logic                        axi_master_aw_valid_o,
    output logic [AXI_ADDR_WIDTH-1:0]   axi_master_aw_addr_o,
    output logic [2:0]                  axi_master_aw_prot_o,
    output logic [3:0]                  axi_master_aw_region_o,
    output logic [7:0]                  axi_master_aw_len_o,
    output logic [2:0]                  axi_master_aw_size_o,
    output logic [1:0]                  axi_master_aw_burst_o,
    output logic                        axi_master_aw_lock_o,
    output logic [3:0]                  axi_master_aw_cache_o,
    output logic [3:0]                  axi_master_aw_qos_o,
    output logic [AXI_ID_WIDTH-1:0]     axi_master_aw_id_o,
    output logic [AXI_USER_WIDTH-1:0]   axi_master_aw_user_o,
    input  logic                        axi_master_aw_ready_i,

    // Local W master
    output logic                        axi_master_w_valid_o,
    output logic [AXI_DATA_WIDTH-1:0]   axi_master_w_data_o,
    output logic [AXI_DATA_WIDTH/8-1:0] axi_master_w_strb_o,
    output logic [AXI_USER_WIDTH-1:0]   axi_master_w_user_o,
    output logic                        axi_master_w_last_o,
    input  logic                        axi_master_w_ready_i,

    // Local B master
    input  logic                        axi_master_b_valid_i,
    input  logic [1:0]                  axi_master_b_resp_i,
    input  logic [AXI_ID_WIDTH-1:0]     axi_master_b_id_i,
    input  logic [AXI_USER_WIDTH-1:0]   axi_master_b_user_i,
    output logic                        axi_master_b_ready_o
);

    aw_beat_t aw_async;
    aw_beat_t aw_dc;
    aw_beat_t aw_master;
    w_beat_t  w_async;
    w_beat_t  w_dc;
    w_beat_t  w_master;
    b_beat_t  b_master;
    b_beat_t  b_async;
    logic     aw_dc_valid;
    logic     aw_dc_ready;
    logic     w_dc_valid;
    logic     w_dc_ready;

    // Beat types are sized from the package defaults
    if (AXI_ADDR_WIDTH != axi_dc_pkg::AXI_ADDR_WIDTH ||
        AXI_DATA_WIDTH != axi_dc_pkg::AXI_DATA_WIDTH ||
        AXI_ID_WIDTH   != axi_dc_pkg::AXI_ID_WIDTH   ||
        AXI_USER_WIDTH != axi_dc_pkg::AXI_USER_WIDTH ||
        BUFFER_WIDTH   >  JOHNSON_MAX_WIDTH) begin : gen_width_check
        $error("bridge widths do not match the beat types");
    end

    assign aw_async = '{
        addr:   axi_slave_aw_addr_i,
        prot:   axi_slave_aw_prot_i,
        region: axi_slave_aw_region_i,
        len:    axi_slave_aw_len_i,
        size:   axi_slave_aw_size_i,
        burst:  axi_slave_aw_burst_i,
        lock:   axi_slave_aw_lock_i,
        cache:  axi_slave_aw_cache_i,
        qos:    axi_slave_aw_qos_i,
        id:     axi_slave_aw_id_i,
        user:   axi_slave_aw_user_i
    };

    assign axi_master_aw_addr_o   = aw_master.addr;
    assign axi_master_aw_prot_o   = aw_master.prot;
    assign axi_master_aw_region_o = aw_master.region;
    assign axi_master_aw_len_o    = aw_master.len;
    assign axi_master_aw_size_o   = aw_master.size;
    assign axi_master_aw_burst_o  = aw_master.burst;
    assign axi_master_aw_lock_o   = aw_master.lock;
    assign axi_master_aw_cache_o  = aw_master.cache;
    assign axi_master_aw_qos_o    = aw_master.qos;
    assign axi_master_aw_id_o     = aw_master.id;
    assign axi_master_aw_user_o   = aw_master.user;

    assign w_async = '{
        data: axi_slave_w_data_i,
        strb: axi_slave_w_strb_i,
        user: axi_slave_w_user_i,
        last: axi_slave_w_last_i
    };

    assign axi_master_w_data_o = w_master.data;
    assign axi_master_w_strb_o = w_master.strb;
    assign axi_master_w_user_o = w_master.user;
    assign axi_master_w_last_o = w_master.last;

    assign b_master = '{
        resp: axi_master_b_resp_i,
        id:   axi_master_b_id_i,
        user: axi_master_b_user_i
    };

    assign axi_slave_b_resp_o = b_async.resp;
    assign axi_slave_b_id_o   = b_async.id;
    assign axi_slave_b_user_o = b_async.user;

    dc_token_ring_fifo_dout #(
        .BUFFER_WIDTH ( BUFFER_WIDTH ),
        .T            ( aw_beat_t    )
    ) dc_aw_chan (
        .clk_i          ( clk_i                      ),
        .arst_n_i       ( arst_n_i                   ),
        .write_token_i  ( axi_slave_aw_writetoken_i  ),
        .read_pointer_o ( axi_slave_aw_readpointer_o ),
        .data_async_i   ( aw_async                   ),
        .data_o         ( aw_dc                      ),
        .valid_o        ( aw_dc_valid                ),
        .ready_i        ( aw_dc_ready                )
    );

    axi_single_slice #(
        .T ( aw_beat_t )
    ) buffer_aw_chan (
        .clk_i    ( clk_i                 ),
        .arst_n_i ( arst_n_i              ),
        .valid_i  ( aw_dc_valid           ),
        .ready_o  ( aw_dc_ready           ),
        .data_i   ( aw_dc                 ),
        .valid_o  ( axi_master_aw_valid_o ),
        .ready_i  ( axi_master_aw_ready_i ),
        .data_o   ( aw_master             )
    );

    dc_token_ring_fifo_dout #(
        .BUFFER_WIDTH ( BUFFER_WIDTH ),
        .T            ( w_beat_t     )
    ) dc_w_chan (
        .clk_i          ( clk_i                     ),
        .arst_n_i       ( arst_n_i                  ),
        .write_token_i  ( axi_slave_w_writetoken_i  ),
        .read_pointer_o ( axi_slave_w_readpointer_o ),
        .data_async_i   ( w_async                   ),
        .data_o         ( w_dc                      ),
        .valid_o        ( w_dc_valid                ),
        .ready_i        ( w_dc_ready                )
    );

    axi_single_slice #(
        .T ( w_beat_t )
    ) buffer_w_chan (
        .clk_i    ( clk_i                ),
        .arst_n_i ( arst_n_i             ),
        .valid_i  ( w_dc_valid           ),
        .ready_o  ( w_dc_ready           ),
        .data_i   ( w_dc                 ),
        .valid_o  ( axi_master_w_valid_o ),
        .ready_i  ( axi_master_w_ready_i ),
        .data_o   ( w_master             )
    );

    dc_token_ring_fifo_din #(
        .BUFFER_WIDTH ( BUFFER_WIDTH ),
        .T            ( b_beat_t     )
    ) dc_b_chan (
        .clk_i          ( clk_i                     ),
        .arst_n_i       ( arst_n_i                  ),
        .data_i         ( b_master                  ),
        .valid_i        ( axi_master_b_valid_i      ),
        .ready_o        ( axi_master_b_ready_o      ),
        .write_token_o  ( axi_slave_b_writetoken_o  ),
        .read_pointer_i ( axi_slave_b_readpointer_i ),
        .data_async_o   ( b_async                   )
    );

endmodule

// File: hw/axi_single_slice.sv
/*
 * One-entry valid/ready register slice.
 * Sustains a beat per cycle by accepting while the entry drains.
 */
module axi_single_slice #(
    parameter type T = logic
) (
    input  logic clk_i,
    input  logic arst_n_i,

    input  logic valid_i,
    output logic ready_o,
    input  T     data_i,

    output logic valid_o,
    input  logic ready_i,
    output T     data_o
);

    logic valid_q;
    T     data_q;

    // Empty, or emptied on this edge
    assign ready_o = ~valid_q | ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

    a_hold_while_stalled: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (valid_o && !ready_i) |=> (valid_o && $stable(data_o))
    ) else $error("slice output changed under back-pressure");

endmodule

// File: hw/dc_token_ring_fifo_din.sv
/*
 * Token-ring FIFO, write side.
 * Holds the buffer and the write token here; the remote reader returns
 * its pointer and reads the selected slot combinationally.
 */
module dc_token_ring_fifo_din
    import axi_dc_pkg::*;
#(
    parameter int  BUFFER_WIDTH = axi_dc_pkg::BUFFER_WIDTH,
    parameter type T            = logic
) (
    input  logic                    clk_i,
    input  logic                    arst_n_i,

    input  T                        data_i,
    input  logic                    valid_i,
    output logic                    ready_o,

    output logic [BUFFER_WIDTH-1:0] write_token_o,
    input  logic [BUFFER_WIDTH-1:0] read_pointer_i,
    output T                        data_async_o
);

    T                        mem_q [BUFFER_WIDTH];
    logic [BUFFER_WIDTH-1:0] write_token_q;
    logic [BUFFER_WIDTH-1:0] pointer_meta_q;
    logic [BUFFER_WIDTH-1:0] pointer_sync_q;
    logic                    full;
    logic                    push;
    int unsigned             write_slot;
    int unsigned             read_slot;

    // Remote pointer into our domain
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pointer_meta_q <= '0;
            pointer_sync_q <= '0;
        end else begin
            pointer_meta_q <= read_pointer_i;
            pointer_sync_q <= pointer_meta_q;
        end
    end

    assign full    = johnson_full(JOHNSON_MAX_WIDTH'(write_token_q),
                                  JOHNSON_MAX_WIDTH'(pointer_sync_q), BUFFER_WIDTH);
    assign ready_o = ~full;
    assign push    = valid_i & ready_o;

    assign write_slot = johnson_slot(JOHNSON_MAX_WIDTH'(write_token_q), BUFFER_WIDTH);
    assign read_slot  = johnson_slot(JOHNSON_MAX_WIDTH'(read_pointer_i), BUFFER_WIDTH);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            write_token_q <= '0;
        end else if (push) begin
            write_token_q <= BUFFER_WIDTH'(johnson_next(JOHNSON_MAX_WIDTH'(write_token_q),
                                                        BUFFER_WIDTH));
        end
    end

    // Entry lands on the same edge the token steps
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[write_slot] <= data_i;
        end
    end

    assign write_token_o = write_token_q;

    // Raw remote pointer selects the slot; the reader only looks once
    // our token has reached it
    assign data_async_o = mem_q[read_slot];

    a_no_push_when_full: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (write_token_q == ~read_pointer_i) |=> $stable(write_token_q)
    ) else $error("write token moved while the FIFO was full");

endmodule

// File: hw/dc_token_ring_fifo_dout.sv
/*
 * Token-ring FIFO, read side.
 * The buffer and write token live in the remote clock domain; this side
 * synchronizes the token and owns the read pointer.
 */
module dc_token_ring_fifo_dout
    import axi_dc_pkg::*;
#(
    parameter int  BUFFER_WIDTH = axi_dc_pkg::BUFFER_WIDTH,
    parameter type T            = logic
) (
    input  logic                    clk_i,
    input  logic                    arst_n_i,

    input  logic [BUFFER_WIDTH-1:0] write_token_i,
    output logic [BUFFER_WIDTH-1:0] read_pointer_o,
    input  T                        data_async_i,

    output T                        data_o,
    output logic                    valid_o,
    input  logic                    ready_i
);

    logic [BUFFER_WIDTH-1:0] token_meta_q;
    logic [BUFFER_WIDTH-1:0] token_sync_q;
    logic [BUFFER_WIDTH-1:0] read_pointer_q;
    logic                    pop;

    // Two-flop synchronizer is safe as only one bit flips per step
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            token_meta_q <= '0;
            token_sync_q <= '0;
        end else begin
            token_meta_q <= write_token_i;
            token_sync_q <= token_meta_q;
        end
    end

    assign valid_o = (token_sync_q != read_pointer_q);
    assign pop     = valid_o & ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            read_pointer_q <= '0;
        end else if (pop) begin
            read_pointer_q <= BUFFER_WIDTH'(johnson_next(JOHNSON_MAX_WIDTH'(read_pointer_q),
                                                         BUFFER_WIDTH));
        end
    end

    assign read_pointer_o = read_pointer_q;

    // Remote entry selected by our pointer is settled when valid
    assign data_o = data_async_i;

    a_no_pop_when_empty: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (write_token_i == read_pointer_q) |=> $stable(read_pointer_q)
    ) else $error("read pointer moved while the FIFO was empty");

endmodule

// File: hw/axi_dc_pkg.sv
/*
 * Shared definitions for the dual-clock AXI bridge.
 * Holds default widths, the AW/W/B beat types and the Johnson code helpers.
 */
package axi_dc_pkg;

    localparam int AXI_ADDR_WIDTH    = 32;
    localparam int AXI_DATA_WIDTH    = 64;
    localparam int AXI_ID_WIDTH      = 6;
    localparam int AXI_USER_WIDTH    = 6;
    localparam int BUFFER_WIDTH      = 8;

    // Widest token the helpers handle
    localparam int JOHNSON_MAX_WIDTH = 32;

    typedef struct packed {
        logic [AXI_ADDR_WIDTH-1:0] addr;
        logic [2:0]                prot;
        logic [3:0]                region;
        logic [7:0]                len;
        logic [2:0]                size;
        logic [1:0]                burst;
        logic                      lock;
        logic [3:0]                cache;
        logic [3:0]                qos;
        logic [AXI_ID_WIDTH-1:0]   id;
        logic [AXI_USER_WIDTH-1:0] user;
    } aw_beat_t;

    typedef struct packed {
        logic [AXI_DATA_WIDTH-1:0]   data;
        logic [AXI_DATA_WIDTH/8-1:0] strb;
        logic [AXI_USER_WIDTH-1:0]   user;
        logic                        last;
    } w_beat_t;

    typedef struct packed {
        logic [1:0]                resp;
        logic [AXI_ID_WIDTH-1:0]   id;
        logic [AXI_USER_WIDTH-1:0] user;
    } b_beat_t;

    // Shift left, feed back the inverted top bit of a width-bit code
    function automatic logic [JOHNSON_MAX_WIDTH-1:0] johnson_next(
        input logic [JOHNSON_MAX_WIDTH-1:0] code,
        input int unsigned                  width
    );
        logic [JOHNSON_MAX_WIDTH-1:0] nxt;
        nxt = '0;
        for (int unsigned i = 1; i < JOHNSON_MAX_WIDTH; i++) begin
            if (i < width) begin
                nxt[i] = code[i-1];
            end
        end
        nxt[0] = ~code[width-1];
        return nxt;
    endfunction

    // Position modulo width, from the count of ones and the low bit
    function automatic int unsigned johnson_slot(
        input logic [JOHNSON_MAX_WIDTH-1:0] code,
        input int unsigned                  width
    );
        int unsigned ones;
        ones = 0;
        for (int unsigned i = 0; i < JOHNSON_MAX_WIDTH; i++) begin
            if (i < width && code[i]) begin
                ones++;
            end
        end
        if (code[0]) begin
            return ones % width;
        end
        return (width - ones) % width;
    endfunction

    // Full when the token is the bitwise inverse of the pointer
    function automatic logic johnson_full(
        input logic [JOHNSON_MAX_WIDTH-1:0] token,
        input logic [JOHNSON_MAX_WIDTH-1:0] pointer,
        input int unsigned                  width
    );
        logic full;
        full = 1'b1;
        for (int unsigned i = 0; i < JOHNSON_MAX_WIDTH; i++) begin
            if (i < width && token[i] == pointer[i]) begin
                full = 1'b0;
            end
        end
        return full;
    endfunction

endpackage
